//--- source/lc3b_types.sv
package lc3b_types;

	// one 16-bit word and also the byte address
	typedef logic [15:0] lc3b_word;

	// half of an l2 block as moved upstream
	typedef logic [127:0] lc3b_c_block;

	// full l2 block as moved to and from physical memory
	typedef logic [255:0] lc3b_l2_block;

	// tag in [15:8], line in [7:5] and offset in bit 4
	typedef logic [7:0] lc3b_l2_tag;
	typedef logic [2:0] lc3b_l2_line;
	typedef logic lc3b_l2_offset;

	typedef enum logic [1:0]
	{
		s_idle,
		s_compare,
		s_writeback,
		s_fill
	} l2_state_t;

endpackage : lc3b_types

//--- source/l2_cache_array.sv
`timescale 1ns/1ps

module l2_cache_array #(
	parameter int width = 1
)
(
	input logic clk,
	input logic rst,
	input logic write,
	input lc3b_types::lc3b_l2_line index,
	input logic [width-1:0] datain,
	output logic [width-1:0] dataout
);

	logic [width-1:0] data [8];

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			for (int i = 0; i < 8; i++)
				data[i] <= '0;
		end
		else if (write)
			data[index] <= datain;
	end

	// read is combinational
	assign dataout = data[index];

endmodule : l2_cache_array

//--- source/l2_cache_lru.sv
`timescale 1ns/1ps

module l2_cache_lru
(
	input logic clk,
	input logic rst,
	input logic ld_lru,
	input lc3b_types::lc3b_l2_line index,
	input logic [3:0] way_used,
	output logic [2:0] lru_out
);

	logic [2:0] tree [8];
	logic [2:0] next_tree;

	assign lru_out = tree[index];

	// point away from the way just used
	always_comb
	begin
		next_tree = lru_out;
		if (way_used[0])
			next_tree = {2'b11, lru_out[0]};
		else if (way_used[1])
			next_tree = {2'b10, lru_out[0]};
		else if (way_used[2])
			next_tree = {1'b0, lru_out[1], 1'b1};
		else if (way_used[3])
			next_tree = {1'b0, lru_out[1], 1'b0};
	end

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			for (int i = 0; i < 8; i++)
				tree[i] <= 3'b0;
		end
		else if (ld_lru)
			tree[index] <= next_tree;
	end

endmodule : l2_cache_lru

//--- source/l2_cache_datapath.sv
`timescale 1ns/1ps

module l2_cache_datapath
(
	input logic clk,
	input logic rst,

	input lc3b_types::lc3b_word mem_address,
	input lc3b_types::lc3b_c_block mem_wdata,
	input lc3b_types::lc3b_l2_block pmem_rdata,

	input logic [3:0] ld_way,
	input logic [3:0] way_sel_fill,
	input logic [3:0] ld_tag,
	input logic [3:0] ld_valid,
	input logic [3:0] ld_dirty,
	input logic [3:0] dirty_in,
	input logic ld_hit,
	input logic ld_lru,
	input logic [1:0] datamux_sel,
	input logic [2:0] addrmux_sel,

	output logic hit,
	output logic [3:0] way_hit,
	output logic [3:0] dirty_out,
	output logic [2:0] lru_out,

	output lc3b_types::lc3b_c_block mem_rdata,
	output lc3b_types::lc3b_word pmem_address,
	output lc3b_types::lc3b_l2_block pmem_wdata
);

	import lc3b_types::*;

	lc3b_l2_tag tag;
	lc3b_l2_line line;
	lc3b_l2_offset offset;

	lc3b_l2_block way_in [4];
	lc3b_l2_block way_out [4];
	lc3b_l2_tag tag_out [4];
	logic [3:0] valid_out;
	logic [3:0] way_match;

	lc3b_l2_block sel_block;
	lc3b_l2_block merged;

	assign tag = mem_address[15:8];
	assign line = mem_address[7:5];
	assign offset = mem_address[4];

	genvar w;
	generate
		for (w = 0; w < 4; w++)
		begin : g_way
			// fill takes the memory block, a write hit the merged one
			assign way_in[w] = way_sel_fill[w] ? pmem_rdata : merged;

			l2_cache_array #(.width(256)) i_data
			(
				.clk, .rst,
				.write(ld_way[w]), .index(line),
				.datain(way_in[w]), .dataout(way_out[w])
			);

			l2_cache_array #(.width(8)) i_tag
			(
				.clk, .rst,
				.write(ld_tag[w]), .index(line),
				.datain(tag), .dataout(tag_out[w])
			);

			l2_cache_array #(.width(1)) i_valid
			(
				.clk, .rst,
				.write(ld_valid[w]), .index(line),
				.datain(1'b1), .dataout(valid_out[w])
			);

			l2_cache_array #(.width(1)) i_dirty
			(
				.clk, .rst,
				.write(ld_dirty[w]), .index(line),
				.datain(dirty_in[w]), .dataout(dirty_out[w])
			);

			assign way_match[w] = valid_out[w] && (tag_out[w] == tag);
		end
	endgenerate

	// compare result held for the s_compare cycle
	always_ff @(posedge clk)
	begin
		if (rst)
			way_hit <= 4'b0;
		else if (ld_hit)
			way_hit <= way_match;
	end

	assign hit = |way_hit;

	assign sel_block = way_out[datamux_sel];
	assign pmem_wdata = sel_block;
	assign mem_rdata = offset ? sel_block[255:128] : sel_block[127:0];

	always_comb
	begin
		merged = sel_block;
		if (offset)
			merged[255:128] = mem_wdata;
		else
			merged[127:0] = mem_wdata;
	end

	// request block or victim's block for write-back
	always_comb
	begin
		case (addrmux_sel)
			3'd1: pmem_address = {tag_out[0], line, 5'b0};
			3'd2: pmem_address = {tag_out[1], line, 5'b0};
			3'd3: pmem_address = {tag_out[2], line, 5'b0};
			3'd4: pmem_address = {tag_out[3], line, 5'b0};
			default: pmem_address = {mem_address[15:5], 5'b0};
		endcase
	end

	l2_cache_lru i_lru
	(
		.clk, .rst,
		.ld_lru, .index(line),
		.way_used(way_hit),
		.lru_out
	);

endmodule : l2_cache_datapath

//--- source/l2_cache_control.sv
`timescale 1ns/1ps

module l2_cache_control
(
	input logic clk,
	input logic rst,

	input logic mem_read,
	input logic mem_write,
	output logic mem_resp,

	output logic pmem_read,
	output logic pmem_write,
	input logic pmem_resp,

	input logic hit,
	input logic [3:0] way_hit,
	input logic [3:0] dirty_out,
	input logic [2:0] lru_out,

	output logic [3:0] ld_way,
	output logic [3:0] way_sel_fill,
	output logic [3:0] ld_tag,
	output logic [3:0] ld_valid,
	output logic [3:0] ld_dirty,
	output logic [3:0] dirty_in,
	output logic ld_hit,
	output logic ld_lru,
	output logic [1:0] datamux_sel,
	output logic [2:0] addrmux_sel
);

	import lc3b_types::*;

	l2_state_t state;
	l2_state_t next_state;

	logic [1:0] victim_idx;
	logic [3:0] victim;
	logic [1:0] hit_idx;

	// bit 2 picks the pair, bit 1 or bit 0 the way inside it
	always_comb
	begin
		if (!lru_out[2])
			victim_idx = lru_out[1] ? 2'd1 : 2'd0;
		else
			victim_idx = lru_out[0] ? 2'd3 : 2'd2;
		victim = 4'b0001 << victim_idx;
	end

	always_comb
	begin
		hit_idx = 2'd0;
		for (int i = 0; i < 4; i++)
		begin
			if (way_hit[i])
				hit_idx = 2'(i);
		end
	end

	always_comb
	begin
		next_state = state;
		mem_resp = 1'b0;
		pmem_read = 1'b0;
		pmem_write = 1'b0;
		ld_way = 4'b0;
		way_sel_fill = 4'b0;
		ld_tag = 4'b0;
		ld_valid = 4'b0;
		ld_dirty = 4'b0;
		dirty_in = 4'b0;
		ld_hit = 1'b0;
		ld_lru = 1'b0;
		datamux_sel = victim_idx;
		addrmux_sel = 3'd0;

		case (state)
			s_idle:
			begin
				if (mem_read || mem_write)
				begin
					ld_hit = 1'b1;
					next_state = s_compare;
				end
			end

			s_compare:
			begin
				if (hit)
				begin
					datamux_sel = hit_idx;
					mem_resp = 1'b1;
					ld_lru = 1'b1;
					// merge write data into the hit way and mark it dirty
					if (mem_write)
					begin
						ld_way = way_hit;
						ld_dirty = way_hit;
						dirty_in = way_hit;
					end
					next_state = s_idle;
				end
				else if (|(dirty_out & victim))
					next_state = s_writeback;
				else
					next_state = s_fill;
			end

			s_writeback:
			begin
				pmem_write = 1'b1;
				addrmux_sel = {1'b0, victim_idx} + 3'd1;
				if (pmem_resp)
					next_state = s_fill;
			end

			s_fill:
			begin
				pmem_read = 1'b1;
				if (pmem_resp)
				begin
					ld_way = victim;
					way_sel_fill = victim;
					ld_tag = victim;
					ld_valid = victim;
					// fresh block is clean
					ld_dirty = victim;
					next_state = s_idle;
				end
			end

			default:
				next_state = s_idle;
		endcase
	end

	always_ff @(posedge clk)
	begin
		if (rst)
			state <= s_idle;
		else
			state <= next_state;
	end

endmodule : l2_cache_control

//--- source/l2_cache.sv
`timescale 1ns/1ps

module l2_cache
(
	input logic clk,
	input logic rst,

	input logic mem_read,
	input logic mem_write,
	input lc3b_types::lc3b_word mem_address,
	input lc3b_types::lc3b_c_block mem_wdata,
	output lc3b_types::lc3b_c_block mem_rdata,
	output logic mem_resp,

	output logic pmem_read,
	output logic pmem_write,
	output lc3b_types::lc3b_word pmem_address,
	output lc3b_types::lc3b_l2_block pmem_wdata,
	input lc3b_types::lc3b_l2_block pmem_rdata,
	input logic pmem_resp
);

	logic [3:0] ld_way;
	logic [3:0] way_sel_fill;
	logic [3:0] ld_tag;
	logic [3:0] ld_valid;
	logic [3:0] ld_dirty;
	logic [3:0] dirty_in;
	logic ld_hit;
	logic ld_lru;
	logic [1:0] datamux_sel;
	logic [2:0] addrmux_sel;

	logic hit;
	logic [3:0] way_hit;
	logic [3:0] dirty_out;
	logic [2:0] lru_out;

	l2_cache_control i_control
	(
		.clk, .rst,
		.mem_read, .mem_write, .mem_resp,
		.pmem_read, .pmem_write, .pmem_resp,
		.hit, .way_hit, .dirty_out, .lru_out,
		.ld_way, .way_sel_fill, .ld_tag, .ld_valid, .ld_dirty, .dirty_in,
		.ld_hit, .ld_lru, .datamux_sel, .addrmux_sel
	);

	l2_cache_datapath i_datapath
	(
		.clk, .rst,
		.mem_address, .mem_wdata, .mem_rdata,
		.pmem_rdata, .pmem_address, .pmem_wdata,
		.ld_way, .way_sel_fill, .ld_tag, .ld_valid, .ld_dirty, .dirty_in,
		.ld_hit, .ld_lru, .datamux_sel, .addrmux_sel,
		.hit, .way_hit, .dirty_out, .lru_out
	);

endmodule : l2_cache

//--- verification/l2_cache_clock.sv
`timescale 1ns/1ps

module l2_cache_clock
(
	output logic clk,
	output logic rst
);

	initial
	begin
		clk = 1'b0;
		forever
			#4 clk = ~clk;
	end

	// reset held over four rising edges, released on a falling edge
	initial
	begin
		rst = 1'b1;
		repeat (4)
			@(posedge clk);
		@(negedge clk);
		rst = 1'b0;
	end

endmodule : l2_cache_clock

//--- verification/l2_pmem_model.sv
`timescale 1ns/1ps

module l2_pmem_model
(
	input logic clk,
	input logic rst,
	input logic pmem_read,
	input logic pmem_write,
	input lc3b_types::lc3b_word pmem_address,
	input lc3b_types::lc3b_l2_block pmem_wdata,
	output lc3b_types::lc3b_l2_block pmem_rdata,
	output logic pmem_resp,
	output int read_count,
	output int write_count,
	output lc3b_types::lc3b_word last_write_address
);

	import lc3b_types::*;

	lc3b_l2_block mem [2048];
	int seed = 32'h4f5b_5c85;
	int wait_left = 0;
	logic resp_q = 1'b0;
	lc3b_l2_block rdata_q = '0;
	int reads = 0;
	int writes = 0;
	lc3b_word waddr_q = '0;

	assign pmem_resp = resp_q;
	assign pmem_rdata = rdata_q;
	assign read_count = reads;
	assign write_count = writes;
	assign last_write_address = waddr_q;

	// unwritten blocks hold their own address in every word
	initial
	begin
		for (int i = 0; i < 2048; i++)
			mem[i] = {16{i[10:0], 5'b0}};
	end

	// 1 to 4 wait cycles per transfer, response lasts one cycle
	always @(negedge clk)
	begin
		resp_q <= 1'b0;
		if (rst)
			wait_left <= 0;
		else if ((pmem_read || pmem_write) && !resp_q)
		begin
			if (wait_left == 0)
				wait_left <= 1 + int'($unsigned($random(seed)) % 4);
			else if (wait_left > 1)
				wait_left <= wait_left - 1;
			else
			begin
				wait_left <= 0;
				resp_q <= 1'b1;
				if (pmem_write)
				begin
					mem[pmem_address[15:5]] <= pmem_wdata;
					writes <= writes + 1;
					waddr_q <= pmem_address;
				end
				else
				begin
					rdata_q <= mem[pmem_address[15:5]];
					reads <= reads + 1;
				end
			end
		end
	end

endmodule : l2_pmem_model

//--- verification/l2_cache_assertions.sv
`timescale 1ns/1ps

module l2_cache_assertions
(
	input logic clk,
	input logic rst,
	input logic mem_read,
	input logic mem_write,
	input logic mem_resp,
	input logic pmem_read,
	input logic pmem_write,
	input lc3b_types::lc3b_word pmem_address
);

	int fail_count = 0;

	resp_with_request: assert property (@(posedge clk) disable iff (rst)
		mem_resp |-> (mem_read || mem_write))
	else
	begin
		fail_count++;
		$error("mem_resp raised with no request pending");
	end

	pmem_exclusive: assert property (@(posedge clk) disable iff (rst)
		!(pmem_read && pmem_write))
	else
	begin
		fail_count++;
		$error("pmem_read and pmem_write high together");
	end

	resp_one_cycle: assert property (@(posedge clk) disable iff (rst)
		mem_resp |=> !mem_resp)
	else
	begin
		fail_count++;
		$error("mem_resp held longer than one cycle");
	end

	// memory side moves whole blocks only
	pmem_aligned: assert property (@(posedge clk) disable iff (rst)
		(pmem_read || pmem_write) |-> (pmem_address[4:0] == 5'b0))
	else
	begin
		fail_count++;
		$error("pmem_address not block aligned");
	end

endmodule : l2_cache_assertions

bind l2_cache l2_cache_assertions i_assertions
(
	.clk, .rst,
	.mem_read, .mem_write, .mem_resp,
	.pmem_read, .pmem_write, .pmem_address
);

//--- verification/l2_cache_tb.sv
`timescale 1ns/1ps

module l2_cache_tb;

	import lc3b_types::*;

	localparam int num_tests = 5;
	localparam int random_ops = 200;
	// directed tests get 200 cycles each and random requests 20 each
	localparam int watchdog_cycles = num_tests * 200 + random_ops * 20;

	logic clk;
	logic rst;
	logic mem_read;
	logic mem_write;
	lc3b_word mem_address;
	lc3b_c_block mem_wdata;
	lc3b_c_block mem_rdata;
	logic mem_resp;
	logic pmem_read;
	logic pmem_write;
	lc3b_word pmem_address;
	lc3b_l2_block pmem_wdata;
	lc3b_l2_block pmem_rdata;
	logic pmem_resp;
	int read_count;
	int write_count;
	lc3b_word last_write_address;

	lc3b_l2_block ref_mem [2048];
	int seed = 32'h4f5b_5c85;
	int errors = 0;
	int test_start_errors = 0;
	int tests_failed = 0;

	l2_cache_clock i_clock (.clk, .rst);

	l2_cache i_l2_cache
	(
		.clk, .rst,
		.mem_read, .mem_write, .mem_address, .mem_wdata, .mem_rdata, .mem_resp,
		.pmem_read, .pmem_write, .pmem_address, .pmem_wdata, .pmem_rdata, .pmem_resp
	);

	l2_pmem_model i_pmem
	(
		.clk, .rst,
		.pmem_read, .pmem_write, .pmem_address, .pmem_wdata, .pmem_rdata, .pmem_resp,
		.read_count, .write_count, .last_write_address
	);

	task automatic check_data(input string name, input lc3b_c_block actual,
		input lc3b_c_block expected);
		assert (actual === expected)
		else
		begin
			$display("ERROR %0t %s: expected %h, got %h", $time, name, expected, actual);
			errors++;
		end
	endtask

	task automatic check_number(input string name, input int actual, input int expected);
		assert (actual == expected)
		else
		begin
			$display("ERROR %0t %s: expected %0d, got %0d", $time, name, expected, actual);
			errors++;
		end
	endtask

	// one request held until mem_resp and released on the following falling edge
	task automatic access(input logic write, input lc3b_word address,
		input lc3b_c_block wdata, output int cycles);
		lc3b_c_block expected;
		mem_address = address;
		mem_wdata = wdata;
		mem_read = !write;
		mem_write = write;
		cycles = 1;
		do
		begin
			@(negedge clk);
			cycles++;
		end
		while (!mem_resp);
		if (write && address[4])
			ref_mem[address[15:5]][255:128] = wdata;
		else if (write)
			ref_mem[address[15:5]][127:0] = wdata;
		else
		begin
			expected = address[4] ? ref_mem[address[15:5]][255:128]
				: ref_mem[address[15:5]][127:0];
			check_data("mem_rdata", mem_rdata, expected);
		end
		@(negedge clk);
		mem_read = 1'b0;
		mem_write = 1'b0;
	endtask

	task automatic report_test(input int number, input string name);
		int found;
		found = errors - test_start_errors;
		if (found != 0)
			tests_failed++;
		$display("test %0d %s: %s, %0d errors", number, name,
			(found == 0) ? "passed" : "failed", found);
		test_start_errors = errors;
	endtask

	initial
	begin
		repeat (watchdog_cycles)
			@(posedge clk);
		$display("watchdog expired after %0d cycles, a request never finished",
			watchdog_cycles);
		$display("TEST FAILED");
		$finish;
	end

	initial
	begin
		int cycles;
		int reads_before;
		int assert_fails;
		logic [31:0] r;
		lc3b_word address;
		lc3b_c_block data;

		mem_read = 1'b0;
		mem_write = 1'b0;
		mem_address = '0;
		mem_wdata = '0;
		for (int i = 0; i < 2048; i++)
			ref_mem[i] = {16{i[10:0], 5'b0}};

		wait (rst == 1'b0);
		repeat (4)
		begin
			@(negedge clk);
			check_number("mem_resp", int'(mem_resp), 0);
			check_number("pmem_read", int'(pmem_read), 0);
			check_number("pmem_write", int'(pmem_write), 0);
		end
		report_test(1, "idle after reset");

		access(1'b0, 16'h1230, '0, cycles);
		check_number("read_count", read_count, 1);
		reads_before = read_count;
		access(1'b0, 16'h1230, '0, cycles);
		check_number("read_count", read_count, reads_before);
		check_number("hit latency", cycles, 2);
		report_test(2, "read miss then hit");

		data = 128'h0123_4567_89ab_cdef_fedc_ba98_7654_3210;
		access(1'b1, 16'h1230, data, cycles);
		access(1'b0, 16'h1230, '0, cycles);
		access(1'b0, 16'h1220, '0, cycles);
		check_number("read_count", read_count, reads_before);
		check_number("write_count", write_count, 0);
		report_test(3, "write hit and both halves");

		// five tags in set 3 with the dirty first tag least recently used
		access(1'b0, 16'h4060, '0, cycles);
		access(1'b1, 16'h4070, {4{32'hc0de_0004}}, cycles);
		for (int t = 1; t < 5; t++)
			access(1'b0, {8'h40 + 8'(t), 8'h60}, '0, cycles);
		check_number("write_count", write_count, 1);
		check_number("last_write_address", int'(last_write_address), 32'h4060);
		access(1'b0, 16'h4070, '0, cycles);
		access(1'b0, 16'h4060, '0, cycles);
		report_test(4, "lru eviction with write-back");

		for (int n = 0; n < random_ops; n++)
		begin
			r = $random(seed);
			address = {8'h80 + (r[7:0] % 8'd6), 2'b00, r[8], r[9], 4'b0};
			if (r[10])
			begin
				data = {$random(seed), $random(seed), $random(seed), $random(seed)};
				access(1'b1, address, data, cycles);
			end
			else
				access(1'b0, address, '0, cycles);
		end
		for (int k = 0; k < 24; k++)
			access(1'b0, {8'h80 + 8'(k / 4), 2'b00, 2'(k % 4), 4'b0}, '0, cycles);
		report_test(5, "random reads and writes");

		assert_fails = i_l2_cache.i_assertions.fail_count;
		$display("%0d tests, %0d passed, %0d failed, %0d check errors, %0d assertion failures",
			num_tests, num_tests - tests_failed, tests_failed, errors, assert_fails);
		if (errors == 0 && assert_fails == 0)
			$display("TEST OK");
		else
			$display("TEST FAILED");
		$finish;
	end

endmodule : l2_cache_tb

//--- vlog.f
source/lc3b_types.sv
source/l2_cache_array.sv
source/l2_cache_lru.sv
source/l2_cache_datapath.sv
source/l2_cache_control.sv
source/l2_cache.sv
verification/l2_cache_clock.sv
verification/l2_pmem_model.sv
verification/l2_cache_assertions.sv
verification/l2_cache_tb.sv

//--- Makefile
TOP := l2_cache_tb
SOURCES := $(wildcard source/*.sv verification/*.sv)

all: run

obj_dir/V$(TOP): $(SOURCES) vlog.f
	verilator --binary --timing --assert --timescale 1ns/1ps -f vlog.f --top-module $(TOP)

run: obj_dir/V$(TOP)
	@out="$$(./obj_dir/V$(TOP) +verilator+error+limit+100)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx 'TEST OK'

clean:
	rm -rf obj_dir

.PHONY: all run clean
